//--- verilog/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// register file geometry and reset contents.
`define RV_NUM_REGS     32
`define RV_SP_IDX       2
`define RV_RESET_SP     32'h1000_03FC

// major opcodes handled by the cluster.
`define RV_OP_REG       7'b0110011
`define RV_OP_IMM       7'b0010011
`define RV_OP_LUI       7'b0110111

`define RV_F3_ADD_SUB   3'b000
`define RV_F3_SLL       3'b001
`define RV_F3_SLT       3'b010
`define RV_F3_SLTU      3'b011
`define RV_F3_XOR       3'b100
`define RV_F3_SRL_SRA   3'b101
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111

`define RV_F7_BASE      7'b0000000
`define RV_F7_ALT       7'b0100000

`endif

//--- verilog/rv_pkg.sv
package rv_pkg;

        // register data, instruction words and results.
        typedef logic [31:0] word_t;

        // architectural register index.
        typedef logic [4:0] reg_idx_t;

        // lui uses pass_b to forward the immediate.
        typedef enum logic [3:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_SLL,
                ALU_SLT,
                ALU_SLTU,
                ALU_XOR,
                ALU_SRL,
                ALU_SRA,
                ALU_OR,
                ALU_AND,
                ALU_PASS_B
        } alu_op_t;

        // one instruction in flight, read then execute then retire.
        typedef enum logic [1:0] {
                ST_IDLE,
                ST_READ,
                ST_EXEC,
                ST_RETIRE
        } exec_state_t;

endpackage

//--- verilog/rv_regfile_if.sv
`timescale 1ns/1ps

interface rv_regfile_if import rv_pkg::*; ();

        // read request and registered read data.
        logic     rd_en;
        reg_idx_t rs1_idx;
        reg_idx_t rs2_idx;
        word_t    rs1_data;
        word_t    rs2_data;

        // write-back port.
        logic     wr_en;
        reg_idx_t wr_idx;
        word_t    wr_data;

        modport ctrl (
                output rd_en, rs1_idx, rs2_idx,
                input  rs1_data, rs2_data,
                output wr_en, wr_idx, wr_data
        );

        modport regs (
                input  rd_en, rs1_idx, rs2_idx,
                output rs1_data, rs2_data,
                input  wr_en, wr_idx, wr_data
        );

endinterface

//--- verilog/rv_registers.sv
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_registers import rv_pkg::*; (
        input  logic           i_clock,
        input  logic           i_reset,
        rv_regfile_if.regs     regs
);

        word_t gpr_q [`RV_NUM_REGS];
        word_t rs1_q;
        word_t rs2_q;

        assign regs.rs1_data = rs1_q;
        assign regs.rs2_data = rs2_q;

        always_ff @(posedge i_clock or posedge i_reset) begin
                if (i_reset) begin
                        rs1_q <= '0;
                        rs2_q <= '0;
                        // stack pointer starts at the top of data memory.
                        for (int i = 0; i < `RV_NUM_REGS; i++) begin
                                gpr_q[i] <= (i == `RV_SP_IDX) ? `RV_RESET_SP : '0;
                        end
                end else begin
                        if (regs.rd_en) begin
                                rs1_q <= (regs.rs1_idx != '0) ? gpr_q[regs.rs1_idx] : '0;
                                rs2_q <= (regs.rs2_idx != '0) ? gpr_q[regs.rs2_idx] : '0;
                        end
                        // x0 may hold junk here, reads mask it.
                        if (regs.wr_en) begin
                                gpr_q[regs.wr_idx] <= regs.wr_data;
                        end
                end
        end

        // x0 reads back as zero on both ports.
        a_rs1_zero: assert property (
                @(posedge i_clock) disable iff (i_reset)
                regs.rd_en && (regs.rs1_idx == '0) |=> (regs.rs1_data == '0)
        );

        a_rs2_zero: assert property (
                @(posedge i_clock) disable iff (i_reset)
                regs.rd_en && (regs.rs2_idx == '0) |=> (regs.rs2_data == '0)
        );

endmodule

//--- verilog/rv_decoder.sv
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_decoder import rv_pkg::*; (
        input  word_t    i_instr,
        output reg_idx_t o_rs1_idx,
        output reg_idx_t o_rs2_idx,
        output reg_idx_t o_rd_idx,
        output alu_op_t  o_alu_op,
        output word_t    o_imm,
        output logic     o_use_imm,
        output logic     o_illegal
);

        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        logic       f7_alt;
        logic       is_shift;
        alu_op_t    base_op;

        assign opcode = i_instr[6:0];
        assign funct3 = i_instr[14:12];
        assign funct7 = i_instr[31:25];

        assign o_rd_idx  = i_instr[11:7];
        assign o_rs1_idx = i_instr[19:15];
        assign o_rs2_idx = i_instr[24:20];

        assign f7_alt   = (funct7 == `RV_F7_ALT);
        assign is_shift = (funct3 == `RV_F3_SLL) || (funct3 == `RV_F3_SRL_SRA);

        // operation implied by funct3 alone.
        always_comb begin
                case (funct3)
                        `RV_F3_ADD_SUB: base_op = ALU_ADD;
                        `RV_F3_SLL:     base_op = ALU_SLL;
                        `RV_F3_SLT:     base_op = ALU_SLT;
                        `RV_F3_SLTU:    base_op = ALU_SLTU;
                        `RV_F3_XOR:     base_op = ALU_XOR;
                        `RV_F3_SRL_SRA: base_op = ALU_SRL;
                        `RV_F3_OR:      base_op = ALU_OR;
                        default:        base_op = ALU_AND;
                endcase
        end

        always_comb begin
                o_alu_op  = base_op;
                o_imm     = {{20{i_instr[31]}}, i_instr[31:20]};
                o_use_imm = 1'b0;
                o_illegal = 1'b0;
                case (opcode)
                        `RV_OP_REG: begin
                                if (f7_alt && (funct3 == `RV_F3_ADD_SUB)) begin
                                        o_alu_op = ALU_SUB;
                                end else if (f7_alt && (funct3 == `RV_F3_SRL_SRA)) begin
                                        o_alu_op = ALU_SRA;
                                end else if (funct7 != `RV_F7_BASE) begin
                                        o_illegal = 1'b1;
                                end
                        end
                        `RV_OP_IMM: begin
                                o_use_imm = 1'b1;
                                // shift amount lives in the rs2 field.
                                if (is_shift) begin
                                        o_imm = {27'd0, i_instr[24:20]};
                                        if (f7_alt && (funct3 == `RV_F3_SRL_SRA)) begin
                                                o_alu_op = ALU_SRA;
                                        end else if (funct7 != `RV_F7_BASE) begin
                                                o_illegal = 1'b1;
                                        end
                                end
                        end
                        `RV_OP_LUI: begin
                                o_alu_op  = ALU_PASS_B;
                                o_imm     = {i_instr[31:12], 12'd0};
                                o_use_imm = 1'b1;
                        end
                        default: begin
                                o_illegal = 1'b1;
                        end
                endcase
        end

endmodule

//--- verilog/rv_alu.sv
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
        input  alu_op_t i_op,
        input  word_t   i_a,
        input  word_t   i_b,
        output word_t   o_result
);

        logic [4:0] shamt;

        // only the low five bits count for shifts.
        assign shamt = i_b[4:0];

        always_comb begin
                case (i_op)
                        ALU_ADD: begin
                                o_result = i_a + i_b;
                        end
                        ALU_SUB: begin
                                o_result = i_a - i_b;
                        end
                        ALU_SLL: begin
                                o_result = i_a << shamt;
                        end
                        ALU_SLT: begin
                                o_result = word_t'($signed(i_a) < $signed(i_b));
                        end
                        ALU_SLTU: begin
                                o_result = word_t'(i_a < i_b);
                        end
                        ALU_XOR: begin
                                o_result = i_a ^ i_b;
                        end
                        ALU_SRL: begin
                                o_result = i_a >> shamt;
                        end
                        ALU_SRA: begin
                                o_result = word_t'($signed(i_a) >>> shamt);
                        end
                        ALU_OR: begin
                                o_result = i_a | i_b;
                        end
                        ALU_AND: begin
                                o_result = i_a & i_b;
                        end
                        ALU_PASS_B: begin
                                o_result = i_b;
                        end
                        default: begin
                                o_result = '0;
                        end
                endcase
        end

endmodule

//--- verilog/rv_exec_sequencer.sv
`timescale 1ns/1ps

module rv_exec_sequencer import rv_pkg::*; (
        input  logic           i_clock,
        input  logic           i_reset,

        input  logic           i_instr_valid,
        input  word_t          i_instr,
        output logic           o_instr_ready,

        output logic           o_retire_valid,
        output reg_idx_t       o_retire_rd,
        output word_t          o_retire_value,
        output logic           o_retire_illegal,
        input  logic           i_retire_ready,

        rv_regfile_if.ctrl     rf
);

        exec_state_t state_q;
        exec_state_t state_d;
        logic        ready_q;
        logic        instr_fire;
        logic        retire_fire;

        word_t       instr_q;
        word_t       retire_value_q;
        reg_idx_t    retire_rd_q;
        logic        retire_illegal_q;

        reg_idx_t    dec_rs1_idx;
        reg_idx_t    dec_rs2_idx;
        reg_idx_t    dec_rd_idx;
        alu_op_t     dec_alu_op;
        word_t       dec_imm;
        logic        dec_use_imm;
        logic        dec_illegal;
        word_t       alu_b;
        word_t       alu_result;

        rv_decoder u_decoder (
                .i_instr   (instr_q),
                .o_rs1_idx (dec_rs1_idx),
                .o_rs2_idx (dec_rs2_idx),
                .o_rd_idx  (dec_rd_idx),
                .o_alu_op  (dec_alu_op),
                .o_imm     (dec_imm),
                .o_use_imm (dec_use_imm),
                .o_illegal (dec_illegal)
        );

        assign alu_b = dec_use_imm ? dec_imm : rf.rs2_data;

        rv_alu u_alu (
                .i_op     (dec_alu_op),
                .i_a      (rf.rs1_data),
                .i_b      (alu_b),
                .o_result (alu_result)
        );

        assign instr_fire  = i_instr_valid && ready_q;
        assign retire_fire = (state_q == ST_RETIRE) && i_retire_ready;

        always_comb begin
                state_d = state_q;
                case (state_q)
                        ST_IDLE:   if (instr_fire) state_d = ST_READ;
                        ST_READ:   state_d = ST_EXEC;
                        ST_EXEC:   state_d = ST_RETIRE;
                        ST_RETIRE: if (retire_fire) state_d = ST_IDLE;
                        default:   state_d = ST_IDLE;
                endcase
        end

        // ready is registered so it stays low while reset is held.
        always_ff @(posedge i_clock or posedge i_reset) begin
                if (i_reset) begin
                        state_q <= ST_IDLE;
                        ready_q <= 1'b0;
                end else begin
                        state_q <= state_d;
                        ready_q <= (state_d == ST_IDLE);
                end
        end

        always_ff @(posedge i_clock) begin
                if (instr_fire) begin
                        instr_q <= i_instr;
                end
                if (state_q == ST_EXEC) begin
                        retire_value_q   <= alu_result;
                        retire_rd_q      <= dec_rd_idx;
                        retire_illegal_q <= dec_illegal;
                end
        end

        assign o_instr_ready    = ready_q;
        assign o_retire_valid   = (state_q == ST_RETIRE);
        assign o_retire_rd      = retire_rd_q;
        assign o_retire_value   = retire_value_q;
        assign o_retire_illegal = retire_illegal_q;

        assign rf.rd_en   = (state_q == ST_READ);
        assign rf.rs1_idx = dec_rs1_idx;
        assign rf.rs2_idx = dec_rs2_idx;
        assign rf.wr_en   = retire_fire && !retire_illegal_q;
        assign rf.wr_idx  = retire_rd_q;
        assign rf.wr_data = retire_value_q;

        a_retire_stable: assert property (
                @(posedge i_clock) disable iff (i_reset)
                o_retire_valid && !i_retire_ready |=> o_retire_valid &&
                        $stable(o_retire_value) && $stable(o_retire_rd) &&
                        $stable(o_retire_illegal)
        );

        // the latched word still decodes to a legal write of the same rd.
        a_no_illegal_write: assert property (
                @(posedge i_clock) disable iff (i_reset)
                rf.wr_en |-> !dec_illegal && (rf.wr_idx == dec_rd_idx)
        );

endmodule

//--- verilog/rv_exec_top.sv
`timescale 1ns/1ps

module rv_exec_top import rv_pkg::*; (
        input  logic     i_clock,
        input  logic     i_reset,

        input  logic     i_instr_valid,
        input  word_t    i_instr,
        output logic     o_instr_ready,

        output logic     o_retire_valid,
        output reg_idx_t o_retire_rd,
        output word_t    o_retire_value,
        output logic     o_retire_illegal,
        input  logic     i_retire_ready
);

        rv_regfile_if rf_if ();

        rv_exec_sequencer u_sequencer (
                .i_clock          (i_clock),
                .i_reset          (i_reset),
                .i_instr_valid    (i_instr_valid),
                .i_instr          (i_instr),
                .o_instr_ready    (o_instr_ready),
                .o_retire_valid   (o_retire_valid),
                .o_retire_rd      (o_retire_rd),
                .o_retire_value   (o_retire_value),
                .o_retire_illegal (o_retire_illegal),
                .i_retire_ready   (i_retire_ready),
                .rf               (rf_if.ctrl)
        );

        rv_registers u_registers (
                .i_clock (i_clock),
                .i_reset (i_reset),
                .regs    (rf_if.regs)
        );

endmodule

//--- bench/rv_exec_tb.sv
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_exec_tb import rv_pkg::*; ();

        localparam int WAIT_LIMIT = 50;
        // accept edge, read edge, exec edge.
        localparam int RETIRE_EDGES = 3;

        logic     i_clock;
        logic     i_reset;
        logic     i_instr_valid;
        word_t    i_instr;
        logic     o_instr_ready;
        logic     o_retire_valid;
        reg_idx_t o_retire_rd;
        word_t    o_retire_value;
        logic     o_retire_illegal;
        logic     i_retire_ready;

        string    t_name[$];
        word_t    t_instr[$];
        reg_idx_t t_rd[$];
        word_t    t_value[$];
        logic     t_illegal[$];

        int       fail_count;
        int       pass_count;
        logic     aborted;

        rv_exec_top DUT (
                .i_clock          (i_clock),
                .i_reset          (i_reset),
                .i_instr_valid    (i_instr_valid),
                .i_instr          (i_instr),
                .o_instr_ready    (o_instr_ready),
                .o_retire_valid   (o_retire_valid),
                .o_retire_rd      (o_retire_rd),
                .o_retire_value   (o_retire_value),
                .o_retire_illegal (o_retire_illegal),
                .i_retire_ready   (i_retire_ready)
        );

        initial begin
                i_clock = 1'b0;
                forever #2 i_clock = ~i_clock;
        end

        function automatic word_t r_word(input logic [6:0] f7, input reg_idx_t rs2,
                                         input reg_idx_t rs1, input logic [2:0] f3,
                                         input reg_idx_t rd);
                return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
        endfunction

        function automatic word_t i_word(input logic [11:0] imm, input reg_idx_t rs1,
                                         input logic [2:0] f3, input reg_idx_t rd);
                return {imm, rs1, f3, rd, `RV_OP_IMM};
        endfunction

        function automatic word_t u_word(input logic [19:0] imm, input reg_idx_t rd);
                return {imm, rd, `RV_OP_LUI};
        endfunction

        task automatic add_test(input string name, input word_t instr, input reg_idx_t rd,
                                input word_t value, input logic illegal);
                t_name.push_back(name);
                t_instr.push_back(instr);
                t_rd.push_back(rd);
                t_value.push_back(value);
                t_illegal.push_back(illegal);
        endtask

        // each entry relies on the registers written by the entries above it.
        task automatic build_table();
                add_test("add_sp", r_word(`RV_F7_BASE, 5'd0, 5'd2, `RV_F3_ADD_SUB, 5'd5),
                         5'd5, `RV_RESET_SP, 1'b0);
                add_test("add_reset_zero", r_word(`RV_F7_BASE, 5'd0, 5'd7, `RV_F3_ADD_SUB, 5'd6),
                         5'd6, 32'h0000_0000, 1'b0);
                add_test("addi_neg1", i_word(12'hFFF, 5'd0, `RV_F3_ADD_SUB, 5'd1),
                         5'd1, 32'hFFFF_FFFF, 1'b0);
                add_test("addi_min", i_word(12'h800, 5'd0, `RV_F3_ADD_SUB, 5'd3),
                         5'd3, 32'hFFFF_F800, 1'b0);
                add_test("slti_neg", i_word(12'h000, 5'd1, `RV_F3_SLT, 5'd4),
                         5'd4, 32'h0000_0001, 1'b0);
                add_test("sltiu_sext", i_word(12'hFFF, 5'd0, `RV_F3_SLTU, 5'd9),
                         5'd9, 32'h0000_0001, 1'b0);
                add_test("sltiu_max", i_word(12'h001, 5'd1, `RV_F3_SLTU, 5'd10),
                         5'd10, 32'h0000_0000, 1'b0);
                add_test("xori", i_word(12'h555, 5'd1, `RV_F3_XOR, 5'd11),
                         5'd11, 32'hFFFF_FAAA, 1'b0);
                add_test("ori", i_word(12'h7F0, 5'd0, `RV_F3_OR, 5'd12),
                         5'd12, 32'h0000_07F0, 1'b0);
                add_test("andi", i_word(12'h0F0, 5'd11, `RV_F3_AND, 5'd13),
                         5'd13, 32'h0000_00A0, 1'b0);
                add_test("lui_min", u_word(20'h80000, 5'd14), 5'd14, 32'h8000_0000, 1'b0);
                add_test("lui_max", u_word(20'h7FFFF, 5'd18), 5'd18, 32'h7FFF_F000, 1'b0);
                add_test("slli", i_word(12'h004, 5'd12, `RV_F3_SLL, 5'd15),
                         5'd15, 32'h0000_7F00, 1'b0);
                add_test("srli", i_word(12'h004, 5'd14, `RV_F3_SRL_SRA, 5'd16),
                         5'd16, 32'h0800_0000, 1'b0);
                add_test("srai", i_word(12'h404, 5'd14, `RV_F3_SRL_SRA, 5'd17),
                         5'd17, 32'hF800_0000, 1'b0);
                add_test("add_wrap", r_word(`RV_F7_BASE, 5'd4, 5'd1, `RV_F3_ADD_SUB, 5'd20),
                         5'd20, 32'h0000_0000, 1'b0);
                add_test("sub", r_word(`RV_F7_ALT, 5'd14, 5'd18, `RV_F3_ADD_SUB, 5'd21),
                         5'd21, 32'hFFFF_F000, 1'b0);
                add_test("slt_neg", r_word(`RV_F7_BASE, 5'd12, 5'd14, `RV_F3_SLT, 5'd22),
                         5'd22, 32'h0000_0001, 1'b0);
                add_test("sltu_neg", r_word(`RV_F7_BASE, 5'd12, 5'd14, `RV_F3_SLTU, 5'd23),
                         5'd23, 32'h0000_0000, 1'b0);
                add_test("sra", r_word(`RV_F7_ALT, 5'd4, 5'd3, `RV_F3_SRL_SRA, 5'd24),
                         5'd24, 32'hFFFF_FC00, 1'b0);
                add_test("srl", r_word(`RV_F7_BASE, 5'd4, 5'd3, `RV_F3_SRL_SRA, 5'd25),
                         5'd25, 32'h7FFF_FC00, 1'b0);
                add_test("and", r_word(`RV_F7_BASE, 5'd12, 5'd11, `RV_F3_AND, 5'd26),
                         5'd26, 32'h0000_02A0, 1'b0);
                add_test("or", r_word(`RV_F7_BASE, 5'd15, 5'd13, `RV_F3_OR, 5'd27),
                         5'd27, 32'h0000_7FA0, 1'b0);
                add_test("xor", r_word(`RV_F7_BASE, 5'd1, 5'd11, `RV_F3_XOR, 5'd28),
                         5'd28, 32'h0000_0555, 1'b0);
                add_test("sll_reg", r_word(`RV_F7_BASE, 5'd9, 5'd12, `RV_F3_SLL, 5'd29),
                         5'd29, 32'h0000_0FE0, 1'b0);
                add_test("addi_x0", i_word(12'h005, 5'd0, `RV_F3_ADD_SUB, 5'd0),
                         5'd0, 32'h0000_0005, 1'b0);
                add_test("add_x0_x0", r_word(`RV_F7_BASE, 5'd0, 5'd0, `RV_F3_ADD_SUB, 5'd8),
                         5'd8, 32'h0000_0000, 1'b0);
                // opcode 7f with rd field 5.
                add_test("bad_opcode", 32'h0000_02FF, 5'd5, 32'h0000_0000, 1'b1);
                add_test("bad_funct7", r_word(7'b0000001, 5'd1, 5'd1, `RV_F3_ADD_SUB, 5'd6),
                         5'd6, 32'h0000_0000, 1'b1);
                add_test("x5_kept", r_word(`RV_F7_BASE, 5'd0, 5'd5, `RV_F3_ADD_SUB, 5'd30),
                         5'd30, `RV_RESET_SP, 1'b0);
                add_test("x6_kept", r_word(`RV_F7_BASE, 5'd0, 5'd6, `RV_F3_ADD_SUB, 5'd31),
                         5'd31, 32'h0000_0000, 1'b0);
        endtask

        task automatic run_test(input int idx);
                int       waited;
                int       edges;
                int       stall;
                logic     ok;
                word_t    held_value;
                reg_idx_t held_rd;
                logic     held_illegal;

                ok = 1'b1;
                i_instr = t_instr[idx];
                i_instr_valid = 1'b1;
                waited = 0;
                while (!o_instr_ready && waited < WAIT_LIMIT) begin
                        @(posedge i_clock);
                        #1;
                        waited++;
                end
                if (!o_instr_ready) begin
                        $display("%s: timed out waiting for o_instr_ready", t_name[idx]);
                        aborted = 1'b1;
                end else begin
                        // ready and valid are both high, so this edge takes the word.
                        @(posedge i_clock);
                        #1;
                        i_instr_valid = 1'b0;
                        i_instr = '0;
                        edges = 1;
                        while (!o_retire_valid && edges < WAIT_LIMIT) begin
                                @(posedge i_clock);
                                #1;
                                edges++;
                        end
                        if (!o_retire_valid) begin
                                $display("%s: timed out waiting for o_retire_valid", t_name[idx]);
                                aborted = 1'b1;
                        end
                end
                if (!aborted) begin
                        assert (edges == RETIRE_EDGES) else begin
                                $display("Fail %s retire latency expected %0d actual %0d",
                                         t_name[idx], RETIRE_EDGES, edges);
                                ok = 1'b0;
                        end
                        assert (!o_instr_ready) else begin
                                $display("%s: o_instr_ready was high while a result waited",
                                         t_name[idx]);
                                ok = 1'b0;
                        end
                        held_value = o_retire_value;
                        held_rd = o_retire_rd;
                        held_illegal = o_retire_illegal;
                        stall = $urandom % 6;
                        repeat (stall) begin
                                @(posedge i_clock);
                                #1;
                                assert (o_retire_valid && o_retire_value === held_value &&
                                        o_retire_rd === held_rd &&
                                        o_retire_illegal === held_illegal) else begin
                                        $display("%s: retire outputs moved while held back",
                                                 t_name[idx]);
                                        ok = 1'b0;
                                end
                        end
                        i_retire_ready = 1'b1;
                        @(posedge i_clock);
                        #1;
                        i_retire_ready = 1'b0;
                        assert (!o_retire_valid) else begin
                                $display("%s: o_retire_valid stayed high after the handshake",
                                         t_name[idx]);
                                ok = 1'b0;
                        end
                        assert (held_rd === t_rd[idx]) else begin
                                $display("Fail %s rd expected %0d actual %0d",
                                         t_name[idx], t_rd[idx], held_rd);
                                ok = 1'b0;
                        end
                        assert (held_illegal === t_illegal[idx]) else begin
                                $display("Fail %s illegal expected %b actual %b",
                                         t_name[idx], t_illegal[idx], held_illegal);
                                ok = 1'b0;
                        end
                        // an illegal word has no defined result.
                        if (!t_illegal[idx]) begin
                                assert (held_value === t_value[idx]) else begin
                                        $display("Fail %s value expected %h actual %h",
                                                 t_name[idx], t_value[idx], held_value);
                                        ok = 1'b0;
                                end
                        end
                end
                if (ok && !aborted) begin
                        pass_count++;
                        $display("pass %s", t_name[idx]);
                end else begin
                        fail_count++;
                end
        endtask

        initial begin
                void'($urandom(32'h4fb9_bd17));
                i_reset = 1'b1;
                i_instr_valid = 1'b0;
                i_instr = '0;
                i_retire_ready = 1'b0;
                fail_count = 0;
                pass_count = 0;
                aborted = 1'b0;
                build_table();
                repeat (10) @(posedge i_clock);
                #1;
                i_reset = 1'b0;
                for (int i = 0; i < t_name.size() && !aborted; i++) begin
                        run_test(i);
                end
                $display("%0d tests in table, %0d passed, %0d failed",
                         t_name.size(), pass_count, fail_count);
                if (fail_count == 0 && !aborted) begin
                        $display("ALL TESTS PASSED");
                end else begin
                        $display("SOME TESTS FAILED");
                end
                $finish;
        end

endmodule

//--- files.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_regfile_if.sv
verilog/rv_registers.sv
verilog/rv_decoder.sv
verilog/rv_alu.sv
verilog/rv_exec_sequencer.sv
verilog/rv_exec_top.sv
bench/rv_exec_tb.sv

//--- Bender.yml
package:
  name: rv_exec

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_pkg.sv
      - verilog/rv_regfile_if.sv
      - verilog/rv_registers.sv
      - verilog/rv_decoder.sv
      - verilog/rv_alu.sv
      - verilog/rv_exec_sequencer.sv
      - verilog/rv_exec_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/rv_exec_tb.sv
